// ==== Bender.yml ====
package:
  name: p4_ingress

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ing_pkg.sv
      - hdl/ing_port_adapt.sv
      - hdl/ing_port_buffer.sv
      - hdl/ing_merge_sched.sv
      - hdl/ing_stats_regs.sv
      - hdl/p4_ingress_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/ingress_asserts.sv
      - testbench/tb_ingress.sv

// ==== hdl/ing_consts.svh ====
// Ingress aggregator constants

`ifndef ING_CONSTS_SVH
`define ING_CONSTS_SVH

// Narrow ingress ports merged onto the wide bus
`define ING_NUM_PORTS       2

// Bytes carried per beat on each side of the width adapter
`define ING_NARROW_BYTES    2
`define ING_WIDE_BYTES      8
`define ING_BEATS_PER_WORD  (`ING_WIDE_BYTES / `ING_NARROW_BYTES)

// Largest packet, in bytes and in wide words
`define ING_MTU_BYTES       64
`define ING_MTU_WORDS       (`ING_MTU_BYTES / `ING_WIDE_BYTES)

// Each port buffer holds two MTUs
`define ING_BUF_DEPTH       (2 * `ING_MTU_WORDS)

// Statistics counter width
`define ING_CNT_WIDTH       32

`endif

// ==== hdl/ing_merge_sched.sv ====
// Round-robin packet scheduler

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module ing_merge_sched (
    input  logic                     ing_16b_phys_ports,
    input  logic                     rst_n,
    input  ing_pkg::wide_beat_t      heads [`ING_NUM_PORTS-1:0],
    input  logic [`ING_NUM_PORTS-1:0] pkt_avail,
    output logic [`ING_NUM_PORTS-1:0] pop,
    output ing_pkg::wide_beat_t      bus_out,
    input  logic                     bus_ready
);

    import ing_pkg::*;

    sched_state_t state;
    port_idx_t    last_port;
    port_idx_t    cur_port;
    port_idx_t    sel_port;
    logic         sel_found;
    logic         xfer;

    //////////////////////////////////////////////////
    // Round-robin pick

    // Search begins at the port after the one served last
    always_comb begin
        port_idx_t cand;
        sel_port  = last_port;
        sel_found = 1'b0;
        for (int i = 1; i <= `ING_NUM_PORTS; i++) begin
            cand = port_idx_t'((int'(last_port) + i) % `ING_NUM_PORTS);
            if (!sel_found && pkt_avail[cand]) begin
                sel_port  = cand;
                sel_found = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Packet FSM

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SCHED_IDLE;
            last_port <= port_idx_t'(`ING_NUM_PORTS - 1);
            cur_port  <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (sel_found) begin
                        cur_port <= sel_port;
                        state    <= SCHED_STREAM;
                    end
                end
                SCHED_STREAM: begin
                    // Stay on this port until its last word has gone
                    if (xfer && heads[cur_port].last) begin
                        last_port <= cur_port;
                        state     <= SCHED_IDLE;
                    end
                end
                default: state <= SCHED_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Bus output

    // A stalled word stays put because the head only moves on pop
    assign bus_out = '{
        valid: state == SCHED_STREAM,
        data:  heads[cur_port].data,
        keep:  heads[cur_port].keep,
        last:  heads[cur_port].last,
        user:  heads[cur_port].user
    };

    assign xfer = bus_out.valid && bus_ready;

    always_comb begin
        pop           = '0;
        pop[cur_port] = xfer;
    end

endmodule

`default_nettype wire

// ==== hdl/ing_pkg.sv ====
// Ingress aggregator types

`default_nettype none

`include "ing_consts.svh"

package ing_pkg;

    //////////////////////////////////////////////////
    // Vector types

    typedef logic [$clog2(`ING_NUM_PORTS)-1:0]   port_idx_t;
    typedef logic [`ING_NARROW_BYTES*8-1:0]      narrow_data_t;
    typedef logic [`ING_NARROW_BYTES-1:0]        narrow_keep_t;
    typedef logic [`ING_WIDE_BYTES*8-1:0]        wide_data_t;
    typedef logic [`ING_WIDE_BYTES-1:0]          wide_keep_t;
    // One extra bit so a completely full buffer is representable
    typedef logic [$clog2(`ING_BUF_DEPTH):0]     buf_level_t;
    typedef logic [`ING_CNT_WIDTH-1:0]           cnt_t;

    //////////////////////////////////////////////////
    // Beat structures

    typedef struct packed {
        logic         valid;
        narrow_data_t data;
        narrow_keep_t keep;
        logic         last;
    } narrow_beat_t;

    // User carries the source port on the wide bus
    typedef struct packed {
        logic       valid;
        wide_data_t data;
        wide_keep_t keep;
        logic       last;
        port_idx_t  user;
    } wide_beat_t;

    typedef enum logic {
        SCHED_IDLE,
        SCHED_STREAM
    } sched_state_t;

endpackage

`default_nettype wire

// ==== hdl/ing_port_adapt.sv ====
// Narrow port width adapter

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module ing_port_adapt (
    input  logic                 ing_16b_phys_ports,
    input  logic                 rst_n,
    input  logic                 port_enable,
    input  ing_pkg::narrow_beat_t beat_in,
    output ing_pkg::wide_beat_t  word_out,
    output logic                 start,
    output logic                 drop_evt
);

    import ing_pkg::*;

    localparam int NARROW_BITS = $bits(narrow_data_t);
    localparam int KEEP_BITS   = $bits(narrow_keep_t);
    localparam int IDX_W       = $clog2(`ING_BEATS_PER_WORD);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ING_BEATS_PER_WORD - 1);

    logic             in_pkt;
    logic             pkt_ok;
    logic             first_pend;
    logic [IDX_W-1:0] beat_idx;

    wide_data_t acc_data;
    wide_keep_t acc_keep;
    wide_data_t asm_data;
    wide_keep_t asm_keep;

    logic       out_valid;
    wide_data_t out_data;
    wide_keep_t out_keep;
    logic       out_last;

    logic first_beat;
    logic take;
    logic emit;

    //////////////////////////////////////////////////
    // Beat acceptance

    // The enable is only looked at on the first beat of a packet
    assign first_beat = beat_in.valid && !in_pkt;
    assign take       = beat_in.valid && (first_beat ? port_enable : pkt_ok);
    assign emit       = take && ((beat_idx == LAST_IDX) || beat_in.last);

    // Slot zero opens a fresh word, so stale upper lanes read as zero
    always_comb begin
        asm_data = (beat_idx == '0) ? '0 : acc_data;
        asm_keep = (beat_idx == '0) ? '0 : acc_keep;
        asm_data[beat_idx*NARROW_BITS +: NARROW_BITS] = beat_in.data;
        asm_keep[beat_idx*KEEP_BITS +: KEEP_BITS]     = beat_in.keep;
    end

    //////////////////////////////////////////////////
    // Packet tracking and output pulses

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt     <= 1'b0;
            pkt_ok     <= 1'b0;
            first_pend <= 1'b0;
            beat_idx   <= '0;
            out_valid  <= 1'b0;
            start      <= 1'b0;
            drop_evt   <= 1'b0;
        end else begin
            out_valid <= emit;
            start     <= emit && (first_beat || first_pend);
            drop_evt  <= first_beat && !port_enable;

            if (beat_in.valid) begin
                in_pkt <= !beat_in.last;
            end
            if (first_beat) begin
                pkt_ok     <= port_enable;
                first_pend <= port_enable;
            end
            // Emitting the first word retires the pending start
            if (emit) begin
                first_pend <= 1'b0;
            end
            if (take) begin
                beat_idx <= emit ? '0 : beat_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge ing_16b_phys_ports) begin
        if (take) begin
            acc_data <= asm_data;
            acc_keep <= asm_keep;
        end
        if (emit) begin
            out_data <= asm_data;
            out_keep <= asm_keep;
            out_last <= beat_in.last;
        end
    end

    // The buffer stamps the port index, so user leaves here as zero
    assign word_out = '{
        valid: out_valid,
        data:  out_data,
        keep:  out_keep,
        last:  out_last,
        user:  '0
    };

endmodule

`default_nettype wire

// ==== hdl/ing_port_buffer.sv ====
// Per-port packet buffer

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module ing_port_buffer #(
    parameter int PORT_IDX = 0
) (
    input  logic                ing_16b_phys_ports,
    input  logic                rst_n,
    input  ing_pkg::wide_beat_t word_in,
    input  logic                start,
    output ing_pkg::wide_beat_t head,
    output logic                pkt_avail,
    input  logic                pop,
    output logic                buf_overflow,
    output logic                ovf_drop_evt
);

    import ing_pkg::*;

    localparam int PTR_W = $clog2(`ING_BUF_DEPTH);

    wide_beat_t mem [`ING_BUF_DEPTH-1:0];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    buf_level_t       level;
    buf_level_t       free_words;
    buf_level_t       pkt_count;

    logic pkt_admitted;
    logic room_ok;
    logic wr_en;
    logic rd_en;
    logic wr_last;
    logic rd_last;

    //////////////////////////////////////////////////
    // Admission

    // A packet gets in only if a whole MTU fits when it starts
    assign free_words = buf_level_t'(`ING_BUF_DEPTH) - level;
    assign room_ok    = free_words >= buf_level_t'(`ING_MTU_WORDS);

    assign wr_en   = word_in.valid && (start ? room_ok : pkt_admitted);
    assign rd_en   = pop && (level != '0);
    assign wr_last = wr_en && word_in.last;
    assign rd_last = rd_en && mem[rd_ptr].last;

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            pkt_admitted <= 1'b0;
            buf_overflow <= 1'b0;
            ovf_drop_evt <= 1'b0;
        end else begin
            ovf_drop_evt <= word_in.valid && start && !room_ok;
            if (word_in.valid && start) begin
                pkt_admitted <= room_ok;
                if (!room_ok) begin
                    buf_overflow <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Storage and pointers

    always_ff @(posedge ing_16b_phys_ports) begin
        if (wr_en) begin
            mem[wr_ptr] <= word_in;
        end
    end

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            pkt_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            level <= level + buf_level_t'(wr_en) - buf_level_t'(rd_en);

            // Complete packets in store, counted by their last words
            case ({wr_last, rd_last})
                2'b10:   pkt_count <= pkt_count + 1'b1;
                2'b01:   pkt_count <= pkt_count - 1'b1;
                default: pkt_count <= pkt_count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Show-ahead head

    assign pkt_avail = (pkt_count != '0);

    assign head = '{
        valid: level != '0,
        data:  mem[rd_ptr].data,
        keep:  mem[rd_ptr].keep,
        last:  mem[rd_ptr].last,
        user:  port_idx_t'(PORT_IDX)
    };

endmodule

`default_nettype wire

// ==== hdl/ing_stats_regs.sv ====
// Ingress packet statistics

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module ing_stats_regs (
    input  logic                     ing_16b_phys_ports,
    input  logic                     rst_n,
    input  logic [`ING_NUM_PORTS-1:0] accept_evt,
    input  logic [`ING_NUM_PORTS-1:0] drop_evt,
    input  logic [`ING_NUM_PORTS-1:0] cnt_clear,
    input  logic                     bus_pkt_evt,
    input  logic                     bus_cnt_clear,
    output ing_pkg::cnt_t            pkt_cnt  [`ING_NUM_PORTS-1:0],
    output ing_pkg::cnt_t            drop_cnt [`ING_NUM_PORTS-1:0],
    output ing_pkg::cnt_t            bus_pkt_cnt
);

    import ing_pkg::*;

    // Counters stick at all ones instead of wrapping
    function automatic cnt_t sat_inc(input cnt_t value);
        return (&value) ? value : value + 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Per-port counters

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                pkt_cnt[p]  <= '0;
                drop_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                // Clear takes priority over a same-cycle event
                if (cnt_clear[p]) begin
                    pkt_cnt[p]  <= '0;
                    drop_cnt[p] <= '0;
                end else begin
                    if (accept_evt[p]) begin
                        pkt_cnt[p] <= sat_inc(pkt_cnt[p]);
                    end
                    if (drop_evt[p]) begin
                        drop_cnt[p] <= sat_inc(drop_cnt[p]);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Wide bus counter

    always_ff @(posedge ing_16b_phys_ports or negedge rst_n) begin
        if (!rst_n) begin
            bus_pkt_cnt <= '0;
        end else if (bus_cnt_clear) begin
            bus_pkt_cnt <= '0;
        end else if (bus_pkt_evt) begin
            bus_pkt_cnt <= sat_inc(bus_pkt_cnt);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/p4_ingress_top.sv ====
// Packet router ingress aggregator

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module p4_ingress_top (
    input  logic                     ing_16b_phys_ports,
    input  logic                     rst_n,
    input  ing_pkg::narrow_beat_t    port_in [`ING_NUM_PORTS-1:0],
    input  logic [`ING_NUM_PORTS-1:0] port_enable,
    output ing_pkg::wide_beat_t      bus_out,
    input  logic                     bus_ready,
    output logic [`ING_NUM_PORTS-1:0] buf_overflow,
    input  logic [`ING_NUM_PORTS-1:0] cnt_clear,
    output ing_pkg::cnt_t            pkt_cnt  [`ING_NUM_PORTS-1:0],
    output ing_pkg::cnt_t            drop_cnt [`ING_NUM_PORTS-1:0],
    input  logic                     bus_cnt_clear,
    output ing_pkg::cnt_t            bus_pkt_cnt
);

    import ing_pkg::*;

    wide_beat_t adapt_word [`ING_NUM_PORTS-1:0];
    wide_beat_t buf_head   [`ING_NUM_PORTS-1:0];

    logic [`ING_NUM_PORTS-1:0] adapt_start;
    logic [`ING_NUM_PORTS-1:0] adapt_drop;
    logic [`ING_NUM_PORTS-1:0] ovf_drop;
    logic [`ING_NUM_PORTS-1:0] drop_any;
    logic [`ING_NUM_PORTS-1:0] buf_avail;
    logic [`ING_NUM_PORTS-1:0] buf_pop;
    logic                      bus_pkt_evt;

    //////////////////////////////////////////////////
    // Per-port adapter and buffer

    generate
        for (genvar p = 0; p < `ING_NUM_PORTS; p++) begin : gen_port
            ing_port_adapt u_adapt (
                .ing_16b_phys_ports (ing_16b_phys_ports),
                .rst_n              (rst_n),
                .port_enable        (port_enable[p]),
                .beat_in            (port_in[p]),
                .word_out           (adapt_word[p]),
                .start              (adapt_start[p]),
                .drop_evt           (adapt_drop[p])
            );

            ing_port_buffer #(
                .PORT_IDX (p)
            ) u_buffer (
                .ing_16b_phys_ports (ing_16b_phys_ports),
                .rst_n              (rst_n),
                .word_in            (adapt_word[p]),
                .start              (adapt_start[p]),
                .head               (buf_head[p]),
                .pkt_avail          (buf_avail[p]),
                .pop                (buf_pop[p]),
                .buf_overflow       (buf_overflow[p]),
                .ovf_drop_evt       (ovf_drop[p])
            );
        end
    endgenerate

    // A packet is dropped either at the adapter or at the buffer, never both
    assign drop_any = adapt_drop | ovf_drop;

    //////////////////////////////////////////////////
    // Merge onto the wide bus

    ing_merge_sched u_sched (
        .ing_16b_phys_ports (ing_16b_phys_ports),
        .rst_n              (rst_n),
        .heads              (buf_head),
        .pkt_avail          (buf_avail),
        .pop                (buf_pop),
        .bus_out            (bus_out),
        .bus_ready          (bus_ready)
    );

    assign bus_pkt_evt = bus_out.valid && bus_ready && bus_out.last;

    ing_stats_regs u_stats (
        .ing_16b_phys_ports (ing_16b_phys_ports),
        .rst_n              (rst_n),
        .accept_evt         (adapt_start),
        .drop_evt           (drop_any),
        .cnt_clear          (cnt_clear),
        .bus_pkt_evt        (bus_pkt_evt),
        .bus_cnt_clear      (bus_cnt_clear),
        .pkt_cnt            (pkt_cnt),
        .drop_cnt           (drop_cnt),
        .bus_pkt_cnt        (bus_pkt_cnt)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/ing_pkg.sv
hdl/ing_port_adapt.sv
hdl/ing_port_buffer.sv
hdl/ing_merge_sched.sv
hdl/ing_stats_regs.sv
hdl/p4_ingress_top.sv
testbench/ingress_asserts.sv
testbench/tb_ingress.sv

// ==== testbench/ingress_asserts.sv ====
// Wide bus protocol assertions

`timescale 1ns/1ps
`default_nettype none

module ingress_asserts (
    input logic                ing_16b_phys_ports,
    input logic                rst_n,
    input ing_pkg::wide_beat_t bus_out,
    input logic                bus_ready
);

    // A stalled word stays unchanged until it is taken
    a_hold_stable: assert property (@(posedge ing_16b_phys_ports) disable iff (!rst_n)
        bus_out.valid && !bus_ready |=> $stable(bus_out))
        else $error("bus_out changed while valid was high and ready low");

    a_keep_nonzero: assert property (@(posedge ing_16b_phys_ports) disable iff (!rst_n)
        bus_out.valid |-> bus_out.keep != '0)
        else $error("bus_out carries a word with no valid bytes");

    // The source port cannot change between the words of one packet
    a_user_steady: assert property (@(posedge ing_16b_phys_ports) disable iff (!rst_n)
        bus_out.valid && bus_ready && !bus_out.last |=> bus_out.user == $past(bus_out.user))
        else $error("bus_out user changed in the middle of a packet");

    a_reset_idle: assert property (@(posedge ing_16b_phys_ports)
        !rst_n |-> !bus_out.valid)
        else $error("bus_out valid high during reset");

endmodule

bind p4_ingress_top ingress_asserts u_asserts (
    .ing_16b_phys_ports (ing_16b_phys_ports),
    .rst_n              (rst_n),
    .bus_out            (bus_out),
    .bus_ready          (bus_ready)
);

`default_nettype wire

// ==== testbench/tb_ingress.sv ====
// Ingress aggregator testbench

`timescale 1ns/1ps
`default_nettype none

`include "ing_consts.svh"

module tb_ingress;

    import ing_pkg::*;

    localparam int NP        = `ING_NUM_PORTS;
    localparam int WB        = `ING_WIDE_BYTES;
    localparam int N_ENTRIES = 24;
    localparam logic [31:0] SEED = 32'he2c8_c181;

    localparam logic [1:0] RDY_HIGH = 2'd0;
    localparam logic [1:0] RDY_RAND = 2'd1;
    localparam logic [1:0] RDY_LOW  = 2'd2;

    // One table row drives a packet on each port at once (length zero means no packet)
    typedef struct packed {
        logic [6:0] len0;
        logic [6:0] len1;
        logic [1:0] en;
        logic [1:0] rmode;
        logic       drain;
        logic [2:0] clr;
    } entry_t;

    logic          ing_16b_phys_ports;
    logic          rst_n;
    narrow_beat_t  port_in [NP-1:0];
    logic [NP-1:0] port_enable;
    wide_beat_t    bus_out;
    logic          bus_ready;
    logic [NP-1:0] buf_overflow;
    logic [NP-1:0] cnt_clear;
    cnt_t          pkt_cnt [NP-1:0];
    cnt_t          drop_cnt [NP-1:0];
    logic          bus_cnt_clear;
    cnt_t          bus_pkt_cnt;

    entry_t      stim_tab [N_ENTRIES];
    wide_beat_t  exp_q [NP-1:0][$];
    logic [7:0]  pkt_bytes [NP-1:0][0:63];
    cnt_t        exp_pkt [NP-1:0];
    cnt_t        exp_drop [NP-1:0];
    cnt_t        exp_bus;
    logic        exp_ovf [NP-1:0];
    logic [31:0] data_rng;
    logic [31:0] ready_rng;
    logic [1:0]  ready_mode;
    logic        mid_pkt;
    port_idx_t   mid_port;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          cur_entry = 0;

    p4_ingress_top uut (
        .ing_16b_phys_ports (ing_16b_phys_ports),
        .rst_n              (rst_n),
        .port_in            (port_in),
        .port_enable        (port_enable),
        .bus_out            (bus_out),
        .bus_ready          (bus_ready),
        .buf_overflow       (buf_overflow),
        .cnt_clear          (cnt_clear),
        .pkt_cnt            (pkt_cnt),
        .drop_cnt           (drop_cnt),
        .bus_cnt_clear      (bus_cnt_clear),
        .bus_pkt_cnt        (bus_pkt_cnt)
    );

    initial ing_16b_phys_ports = 1'b0;
    always #50 ing_16b_phys_ports = ~ing_16b_phys_ports;

    //////////////////////////////////////////////////
    // Helpers and checks

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_beat(input string name, input wide_beat_t want,
                              input wide_beat_t got);
        if (got !== want) begin
            stop_with_failure($sformatf("ERR %s: expected %h, actual %h", name, want, got));
        end
    endtask

    task automatic check_cnt(input string name, input cnt_t want, input cnt_t got);
        if (got !== want) begin
            stop_with_failure($sformatf("ERR %s: expected %0d, actual %0d", name, want, got));
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            stop_with_failure($sformatf("ERR %s: expected %b, actual %b", name, want, got));
        end
    endtask

    function automatic int pending_words();
        int n;
        n = 0;
        for (int p = 0; p < NP; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // Reference model

    // Bytes pack from the low lane upward and a packet is refused when less than
    // one MTU of buffer space is free at its start
    task automatic build_expected(input int p, input int len, input logic en);
        wide_beat_t w;
        int         nwords;
        logic       admit;
        if (len == 0) begin
            return;
        end
        for (int i = 0; i < len; i++) begin
            data_rng = lcg_step(data_rng);
            pkt_bytes[p][i] = data_rng[23:16];
        end
        if (!en) begin
            exp_drop[p] = exp_drop[p] + 1'b1;
            return;
        end
        exp_pkt[p] = exp_pkt[p] + 1'b1;
        admit = (`ING_BUF_DEPTH - exp_q[p].size()) >= `ING_MTU_WORDS;
        if (!admit) begin
            exp_drop[p] = exp_drop[p] + 1'b1;
            exp_ovf[p]  = 1'b1;
            return;
        end
        exp_bus = exp_bus + 1'b1;
        nwords  = (len + WB - 1) / WB;
        for (int wi = 0; wi < nwords; wi++) begin
            w       = '0;
            w.valid = 1'b1;
            w.user  = port_idx_t'(p);
            w.last  = (wi == nwords - 1);
            for (int b = 0; b < WB; b++) begin
                if (wi * WB + b < len) begin
                    w.data[b*8 +: 8] = pkt_bytes[p][wi*WB + b];
                    w.keep[b]        = 1'b1;
                end
            end
            exp_q[p].push_back(w);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    task automatic drive_packets(input int len0, input int len1);
        int           lens [NP-1:0];
        int           nbeats;
        int           idx;
        narrow_beat_t nb;
        lens[0] = len0;
        lens[1] = len1;
        nbeats  = ((len0 > len1 ? len0 : len1) + 1) / 2;
        for (int c = 0; c < nbeats; c++) begin
            @(negedge ing_16b_phys_ports);
            for (int p = 0; p < NP; p++) begin
                nb  = '0;
                idx = 2 * c;
                if (idx < lens[p]) begin
                    nb.valid     = 1'b1;
                    nb.data[7:0] = pkt_bytes[p][idx];
                    nb.keep      = 2'b01;
                    // Odd lengths end with a half beat
                    if (idx + 1 < lens[p]) begin
                        nb.data[15:8] = pkt_bytes[p][idx + 1];
                        nb.keep       = 2'b11;
                    end
                    nb.last = (idx + 2 >= lens[p]);
                end
                port_in[p] = nb;
            end
        end
        @(negedge ing_16b_phys_ports);
        for (int p = 0; p < NP; p++) begin
            port_in[p] = '0;
        end
    endtask

    task automatic wait_drain(input logic [1:0] mode);
        ready_mode <= (mode == RDY_LOW) ? RDY_HIGH : mode;
        while (pending_words() != 0) begin
            @(negedge ing_16b_phys_ports);
        end
        // Counters lag their events by a cycle
        repeat (4) @(negedge ing_16b_phys_ports);
    endtask

    task automatic check_counters(input string tag);
        for (int p = 0; p < NP; p++) begin
            check_cnt($sformatf("%s pkt_cnt[%0d]", tag, p), exp_pkt[p], pkt_cnt[p]);
            check_cnt($sformatf("%s drop_cnt[%0d]", tag, p), exp_drop[p], drop_cnt[p]);
            check_flag($sformatf("%s buf_overflow[%0d]", tag, p), exp_ovf[p], buf_overflow[p]);
        end
        check_cnt($sformatf("%s bus_pkt_cnt", tag), exp_bus, bus_pkt_cnt);
    endtask

    task automatic apply_clears(input logic [2:0] clr, input string tag);
        if (clr == '0) begin
            return;
        end
        @(negedge ing_16b_phys_ports);
        cnt_clear     = clr[1:0];
        bus_cnt_clear = clr[2];
        @(negedge ing_16b_phys_ports);
        cnt_clear     = '0;
        bus_cnt_clear = 1'b0;
        for (int p = 0; p < NP; p++) begin
            if (clr[p]) begin
                exp_pkt[p]  = '0;
                exp_drop[p] = '0;
            end
        end
        if (clr[2]) begin
            exp_bus = '0;
        end
        check_counters({tag, " after clear"});
    endtask

    task automatic run_entry(input entry_t e);
        string tag;
        tag = $sformatf("entry %0d", cur_entry);
        @(negedge ing_16b_phys_ports);
        port_enable = e.en;
        ready_mode <= e.rmode;
        build_expected(0, e.len0, e.en[0]);
        build_expected(1, e.len1, e.en[1]);
        drive_packets(e.len0, e.len1);
        if (e.drain) begin
            wait_drain(e.rmode);
            check_counters(tag);
            apply_clears(e.clr, tag);
        end
    endtask

    task automatic load_table();
        // len0, len1, enable per port, ready mode, drain, clears {bus, port1, port0}
        stim_tab[0]  = '{7'd1,  7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[1]  = '{7'd0,  7'd1,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[2]  = '{7'd2,  7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[3]  = '{7'd0,  7'd3,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[4]  = '{7'd7,  7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[5]  = '{7'd0,  7'd8,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[6]  = '{7'd9,  7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[7]  = '{7'd0,  7'd16, 2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[8]  = '{7'd17, 7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[9]  = '{7'd0,  7'd63, 2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[10] = '{7'd64, 7'd0,  2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[11] = '{7'd0,  7'd64, 2'b11, RDY_HIGH, 1'b1, 3'b000};
        // Disabled ports
        stim_tab[12] = '{7'd10, 7'd0,  2'b10, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[13] = '{7'd0,  7'd33, 2'b01, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[14] = '{7'd20, 7'd20, 2'b01, RDY_HIGH, 1'b1, 3'b001};
        // Both ports at once
        stim_tab[15] = '{7'd64, 7'd64, 2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[16] = '{7'd5,  7'd40, 2'b11, RDY_HIGH, 1'b1, 3'b000};
        stim_tab[17] = '{7'd33, 7'd2,  2'b11, RDY_HIGH, 1'b1, 3'b100};
        // Random back-pressure
        stim_tab[18] = '{7'd64, 7'd64, 2'b11, RDY_RAND, 1'b1, 3'b000};
        stim_tab[19] = '{7'd15, 7'd50, 2'b11, RDY_RAND, 1'b1, 3'b000};
        stim_tab[20] = '{7'd1,  7'd1,  2'b11, RDY_RAND, 1'b1, 3'b010};
        // Stalled bus fills port 0 so that the third packet overflows
        stim_tab[21] = '{7'd64, 7'd0,  2'b11, RDY_LOW,  1'b0, 3'b000};
        stim_tab[22] = '{7'd64, 7'd0,  2'b11, RDY_LOW,  1'b0, 3'b000};
        stim_tab[23] = '{7'd64, 7'd0,  2'b11, RDY_LOW,  1'b1, 3'b111};
    endtask

    //////////////////////////////////////////////////
    // Ready pattern, monitor and timeout

    always @(negedge ing_16b_phys_ports) begin
        case (ready_mode)
            RDY_HIGH: bus_ready = 1'b1;
            RDY_RAND: begin
                ready_rng = lcg_step(ready_rng);
                bus_ready = ready_rng[16];
            end
            default:  bus_ready = 1'b0;
        endcase
    end

    always @(posedge ing_16b_phys_ports) begin
        wide_beat_t want;
        if (rst_n && bus_out.valid && bus_ready) begin
            if (mid_pkt && bus_out.user != mid_port) begin
                stop_with_failure($sformatf("Port %0d cut into a packet of port %0d",
                                            bus_out.user, mid_port));
            end else if (exp_q[bus_out.user].size() == 0) begin
                stop_with_failure($sformatf("Unexpected word from port %0d on the bus",
                                            bus_out.user));
            end else begin
                want = exp_q[bus_out.user].pop_front();
                check_beat($sformatf("entry %0d bus word", cur_entry), want, bus_out);
                mid_pkt  = !bus_out.last;
                mid_port = bus_out.user;
            end
        end
    end

    always @(posedge ing_16b_phys_ports) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d words undelivered",
                                        cycle_count, pending_words()));
        end
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        int total_bytes;
        load_table();
        rst_n         = 1'b0;
        port_enable   = '0;
        bus_ready     = 1'b0;
        cnt_clear     = '0;
        bus_cnt_clear = 1'b0;
        ready_mode    = RDY_HIGH;
        data_rng      = SEED;
        ready_rng     = SEED;
        mid_pkt       = 1'b0;
        mid_port      = '0;
        exp_bus       = '0;
        for (int p = 0; p < NP; p++) begin
            port_in[p]  = '0;
            exp_pkt[p]  = '0;
            exp_drop[p] = '0;
            exp_ovf[p]  = 1'b0;
        end
        total_bytes = 0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            total_bytes += int'(stim_tab[i].len0) + int'(stim_tab[i].len1);
        end
        cycle_limit = 40 * total_bytes + 2000;

        repeat (10) @(negedge ing_16b_phys_ports);
        rst_n = 1'b1;
        repeat (2) @(negedge ing_16b_phys_ports);
        check_counters("after reset");

        for (int i = 0; i < N_ENTRIES; i++) begin
            cur_entry = i;
            run_entry(stim_tab[i]);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
